// File: common/alloc_pkg.sv
package alloc_pkg;

  localparam int unsigned data_w = 32;

  typedef logic [data_w-1:0] word_t;

  // heap layout, all in bytes
  localparam word_t word_size             = 32'd4;
  localparam word_t block_header_size     = 32'd8;  // size word, then next pointer
  localparam word_t block_next_ptr_offset = 32'd4;
  localparam word_t block_alignment       = 32'd8;
  localparam word_t min_split_size        = 32'd16;

  localparam word_t null_ptr  = '0;
  localparam word_t err_nomem = '1;

  typedef struct packed {
    word_t size;
    word_t next_ptr;
  } free_block_t;

  typedef enum logic [1:0] {
    cmd_alloc,
    cmd_alloc_zero,
    cmd_free
  } cmd_kind_e;

  typedef enum logic [1:0] {
    lsu_load_word,
    lsu_load_block,
    lsu_store_word,
    lsu_store_block
  } lsu_op_e;

  // round up to the allocation granule
  function automatic word_t align_size(word_t size);
    word_t mask;
    mask = block_alignment - 32'd1;
    return (size + mask) & ~mask;
  endfunction

endpackage

// File: common/cmd_if.sv
`timescale 1ns/1ps

interface cmd_if;
  import alloc_pkg::*;

  logic      valid;
  logic      ready;
  cmd_kind_e kind;
  word_t     operand;  // aligned size or user pointer

  modport decoder (
    output valid, kind, operand,
    input  ready
  );

  modport walker (
    input  valid, kind, operand,
    output ready
  );

endinterface

// File: common/lsu_if.sv
`timescale 1ns/1ps

interface lsu_if;
  import alloc_pkg::*;

  // request half
  logic        req_val;
  logic        req_rdy;
  lsu_op_e     req_op;
  word_t       req_addr;
  word_t       req_word;   // store data for word ops
  free_block_t req_block;  // store data for block ops

  // response half
  logic        rsp_val;
  logic        rsp_rdy;
  word_t       rsp_word;
  free_block_t rsp_block;

  modport walker (
    output req_val, req_op, req_addr, req_word, req_block, rsp_rdy,
    input  req_rdy, rsp_val, rsp_word, rsp_block
  );

  modport unit (
    input  req_val, req_op, req_addr, req_word, req_block, rsp_rdy,
    output req_rdy, rsp_val, rsp_word, rsp_block
  );

endinterface

// File: hw/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             alloc_empty_i,
  output logic             alloc_read_o,
  input  alloc_pkg::word_t alloc_data_i,

  input  logic             free_empty_i,
  output logic             free_read_o,
  input  alloc_pkg::word_t free_data_i,

  cmd_if.decoder           cmd
);
  import alloc_pkg::*;

  logic      valid_q;
  cmd_kind_e kind_q;
  word_t     operand_q;

  // pop only into an empty register, alloc wins
  assign alloc_read_o = !valid_q && !alloc_empty_i;
  assign free_read_o  = !valid_q && alloc_empty_i && !free_empty_i;

  assign cmd.valid   = valid_q;
  assign cmd.kind    = kind_q;
  assign cmd.operand = operand_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (alloc_read_o || free_read_o) begin
      valid_q <= 1'b1;
    end else if (valid_q && cmd.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_read_o) begin
      kind_q    <= (alloc_data_i == '0) ? cmd_alloc_zero : cmd_alloc;
      operand_q <= align_size(alloc_data_i);
    end else if (free_read_o) begin
      kind_q    <= cmd_free;
      operand_q <= free_data_i;  // user pointer, header still in front
    end
  end

  a_one_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alloc_read_o && free_read_o));

endmodule

// File: allocator/block_lsu.sv
`timescale 1ns/1ps

module block_lsu (
  input  logic             clk_i,
  input  logic             rst_ni,

  lsu_if.unit              lsu,

  output logic             mem_req_val_o,
  input  logic             mem_req_rdy_i,
  output logic             mem_req_is_write_o,
  output alloc_pkg::word_t mem_req_addr_o,
  output alloc_pkg::word_t mem_req_data_o,

  input  logic             mem_rsp_val_i,
  output logic             mem_rsp_rdy_o,
  input  alloc_pkg::word_t mem_rsp_data_i
);
  import alloc_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_rsp,
    st_done
  } lsu_state_e;

  lsu_state_e  state_q;
  logic        beat_q;   // 0 size word, 1 next word
  lsu_op_e     op_q;
  word_t       addr_q;
  word_t       wdata_q;
  free_block_t wblock_q;
  free_block_t rblock_q;
  logic        is_block;

  assign is_block = (op_q == lsu_load_block) || (op_q == lsu_store_block);

  assign lsu.req_rdy   = (state_q == st_idle);
  assign lsu.rsp_val   = (state_q == st_done);
  assign lsu.rsp_word  = rblock_q.size;  // word loads land in the size slot
  assign lsu.rsp_block = rblock_q;

  assign mem_req_val_o      = (state_q == st_req);
  assign mem_req_is_write_o = (op_q == lsu_store_word) || (op_q == lsu_store_block);
  assign mem_req_addr_o     = beat_q ? addr_q + word_size : addr_q;
  assign mem_rsp_rdy_o      = (state_q == st_rsp);

  always_comb begin
    if (!is_block) begin
      mem_req_data_o = wdata_q;
    end else begin
      mem_req_data_o = beat_q ? wblock_q.next_ptr : wblock_q.size;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      beat_q  <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (lsu.req_val) begin
            state_q <= st_req;
            beat_q  <= 1'b0;
          end
        end
        st_req: begin
          if (mem_req_rdy_i) state_q <= st_rsp;
        end
        st_rsp: begin
          if (mem_rsp_val_i) begin
            if (is_block && !beat_q) begin
              beat_q  <= 1'b1;
              state_q <= st_req;  // second word of the header
            end else begin
              state_q <= st_done;
            end
          end
        end
        st_done: begin
          if (lsu.rsp_rdy) state_q <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsu.req_val && lsu.req_rdy) begin
      op_q     <= lsu.req_op;
      addr_q   <= lsu.req_addr;
      wdata_q  <= lsu.req_word;
      wblock_q <= lsu.req_block;
    end
    if (mem_rsp_val_i && mem_rsp_rdy_o && !mem_req_is_write_o) begin
      if (beat_q) begin
        rblock_q.next_ptr <= mem_rsp_data_i;
      end else begin
        rblock_q.size <= mem_rsp_data_i;
      end
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_val_o && !mem_req_rdy_i |=> mem_req_val_o && $stable(mem_req_addr_o));

endmodule

// File: allocator/freelist_walker.sv
`timescale 1ns/1ps

module freelist_walker #(
  parameter alloc_pkg::word_t free_list_head_addr = 32'h0000_0000
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  cmd_if.walker            cmd,
  lsu_if.walker            lsu,

  input  logic             resp_full_i,
  output logic             resp_write_o,
  output alloc_pkg::word_t resp_data_o
);
  import alloc_pkg::*;

  typedef enum logic [3:0] {
    st_idle,
    st_ld_head,
    st_wait_head,
    st_check,       // look at next_q, the next block in line
    st_ld_blk,
    st_wait_blk,
    st_fit,
    st_st_size,
    st_st_split,
    st_st_free_next,
    st_st_link,
    st_wait_store,
    st_respond
  } walk_state_e;

  walk_state_e state_q, state_d;
  walk_state_e ret_q, ret_d;  // where a store returns to

  logic        is_free_q;
  word_t       size_q;       // aligned request size
  word_t       free_blk_q;   // header address of the block being freed
  word_t       link_q;       // address of the word that points at next_q
  word_t       next_q;
  word_t       cur_q;        // header address of blk_q
  free_block_t blk_q;
  word_t       link_val_q;   // value written into the link word
  word_t       resp_q;

  word_t remainder;
  word_t split_addr;
  logic  fits;
  logic  do_split;

  assign remainder  = blk_q.size - size_q;
  assign split_addr = cur_q + block_header_size + size_q;
  assign fits       = blk_q.size >= size_q;
  assign do_split   = remainder >= min_split_size;

  assign resp_data_o = resp_q;

  always_comb begin
    state_d       = state_q;
    ret_d         = ret_q;
    cmd.ready     = 1'b0;
    resp_write_o  = 1'b0;
    lsu.req_val   = 1'b0;
    lsu.req_op    = lsu_load_word;
    lsu.req_addr  = free_list_head_addr;
    lsu.req_word  = '0;
    lsu.req_block = '0;
    lsu.rsp_rdy   = 1'b0;

    case (state_q)
      st_idle: begin
        cmd.ready = 1'b1;
        if (cmd.valid) begin
          state_d = (cmd.kind == cmd_alloc_zero) ? st_respond : st_ld_head;
        end
      end

      st_ld_head: begin
        lsu.req_val = 1'b1;
        if (lsu.req_rdy) state_d = st_wait_head;
      end

      st_wait_head: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) state_d = st_check;
      end

      st_check: begin
        if (is_free_q) begin
          // insert point found once the list passes the freed block
          if (next_q == null_ptr || next_q > free_blk_q) begin
            state_d = st_st_free_next;
          end else begin
            state_d = st_ld_blk;
          end
        end else begin
          state_d = (next_q == null_ptr) ? st_respond : st_ld_blk;
        end
      end

      st_ld_blk: begin
        lsu.req_val  = 1'b1;
        lsu.req_op   = lsu_load_block;
        lsu.req_addr = next_q;
        if (lsu.req_rdy) state_d = st_wait_blk;
      end

      st_wait_blk: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) state_d = is_free_q ? st_check : st_fit;
      end

      st_fit: begin
        if (!fits) begin
          state_d = st_check;
        end else begin
          state_d = do_split ? st_st_size : st_st_link;
        end
      end

      st_st_size: begin
        lsu.req_val  = 1'b1;
        lsu.req_op   = lsu_store_word;
        lsu.req_addr = cur_q;
        lsu.req_word = size_q;
        if (lsu.req_rdy) begin
          state_d = st_wait_store;
          ret_d   = st_st_split;
        end
      end

      st_st_split: begin
        lsu.req_val   = 1'b1;
        lsu.req_op    = lsu_store_block;
        lsu.req_addr  = split_addr;
        lsu.req_block = '{size: remainder - block_header_size, next_ptr: blk_q.next_ptr};
        if (lsu.req_rdy) begin
          state_d = st_wait_store;
          ret_d   = st_st_link;
        end
      end

      st_st_free_next: begin
        lsu.req_val  = 1'b1;
        lsu.req_op   = lsu_store_word;
        lsu.req_addr = free_blk_q + block_next_ptr_offset;
        lsu.req_word = next_q;
        if (lsu.req_rdy) begin
          state_d = st_wait_store;
          ret_d   = st_st_link;
        end
      end

      st_st_link: begin
        lsu.req_val  = 1'b1;
        lsu.req_op   = lsu_store_word;
        lsu.req_addr = link_q;
        lsu.req_word = link_val_q;
        if (lsu.req_rdy) begin
          state_d = st_wait_store;
          ret_d   = is_free_q ? st_idle : st_respond;  // free ends silently
        end
      end

      st_wait_store: begin
        lsu.rsp_rdy = 1'b1;
        if (lsu.rsp_val) state_d = ret_q;
      end

      st_respond: begin
        if (!resp_full_i) begin
          resp_write_o = 1'b1;
          state_d      = st_idle;
        end
      end

      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      ret_q   <= st_idle;
    end else begin
      state_q <= state_d;
      ret_q   <= ret_d;
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      st_idle: begin
        if (cmd.valid) begin
          is_free_q  <= (cmd.kind == cmd_free);
          size_q     <= cmd.operand;
          free_blk_q <= cmd.operand - block_header_size;
          link_q     <= free_list_head_addr;
          resp_q     <= null_ptr;  // only seen on zero size
        end
      end
      st_wait_head: begin
        if (lsu.rsp_val) next_q <= lsu.rsp_word;
      end
      st_check: begin
        if (is_free_q) begin
          link_val_q <= free_blk_q;
        end else if (next_q == null_ptr) begin
          resp_q <= err_nomem;
        end
      end
      st_ld_blk: begin
        if (lsu.req_rdy) cur_q <= next_q;
      end
      st_wait_blk: begin
        if (lsu.rsp_val) begin
          blk_q <= lsu.rsp_block;
          if (is_free_q) begin
            link_q <= cur_q + block_next_ptr_offset;
            next_q <= lsu.rsp_block.next_ptr;
          end
        end
      end
      st_fit: begin
        if (!fits) begin
          link_q <= cur_q + block_next_ptr_offset;
          next_q <= blk_q.next_ptr;
        end else begin
          resp_q     <= cur_q + block_header_size;
          link_val_q <= do_split ? split_addr : blk_q.next_ptr;  // split or unlink
        end
      end
      default: ;
    endcase
  end

  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_full_i |-> !resp_write_o);

  a_lsu_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu.req_val && !lsu.req_rdy |=> lsu.req_val && $stable(lsu.req_addr));

endmodule

// File: hw/alloc_core_top.sv
`timescale 1ns/1ps

module alloc_core_top #(
  parameter alloc_pkg::word_t free_list_head_addr = 32'h0000_0000
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             alloc_empty_i,
  output logic             alloc_read_o,
  input  alloc_pkg::word_t alloc_data_i,

  input  logic             free_empty_i,
  output logic             free_read_o,
  input  alloc_pkg::word_t free_data_i,

  input  logic             resp_full_i,
  output logic             resp_write_o,
  output alloc_pkg::word_t resp_data_o,

  output logic             mem_req_val_o,
  input  logic             mem_req_rdy_i,
  output logic             mem_req_is_write_o,
  output alloc_pkg::word_t mem_req_addr_o,
  output alloc_pkg::word_t mem_req_data_o,

  input  logic             mem_rsp_val_i,
  output logic             mem_rsp_rdy_o,
  input  alloc_pkg::word_t mem_rsp_data_i
);

  cmd_if cmd_bus ();
  lsu_if lsu_bus ();

  cmd_decoder dec_i (
    .clk_i,
    .rst_ni,
    .alloc_empty_i,
    .alloc_read_o,
    .alloc_data_i,
    .free_empty_i,
    .free_read_o,
    .free_data_i,
    .cmd (cmd_bus.decoder)
  );

  freelist_walker #(
    .free_list_head_addr (free_list_head_addr)
  ) walker_i (
    .clk_i,
    .rst_ni,
    .cmd (cmd_bus.walker),
    .lsu (lsu_bus.walker),
    .resp_full_i,
    .resp_write_o,
    .resp_data_o
  );

  block_lsu lsu_i (
    .clk_i,
    .rst_ni,
    .lsu (lsu_bus.unit),
    .mem_req_val_o,
    .mem_req_rdy_i,
    .mem_req_is_write_o,
    .mem_req_addr_o,
    .mem_req_data_o,
    .mem_rsp_val_i,
    .mem_rsp_rdy_o,
    .mem_rsp_data_i
  );

endmodule

// File: verif/heap_mem_model.sv
`timescale 1ns/1ps

module heap_mem_model #(
  parameter int latency     = 2,
  parameter int depth_words = 1024
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             req_val_i,
  output logic             req_rdy_o,
  input  logic             req_is_write_i,
  input  alloc_pkg::word_t req_addr_i,
  input  alloc_pkg::word_t req_data_i,

  output logic             rsp_val_o,
  input  logic             rsp_rdy_i,
  output alloc_pkg::word_t rsp_data_o
);
  import alloc_pkg::*;

  word_t words [depth_words];
  logic  busy_q;     // one transaction at a time
  logic  rsp_val_q;
  int    wait_q;
  word_t rdata_q;
  logic [$clog2(depth_words)-1:0] idx;

  assign idx        = req_addr_i[$clog2(depth_words)+1:2];
  assign req_rdy_o  = !busy_q;
  assign rsp_val_o  = rsp_val_q;
  assign rsp_data_o = rdata_q;

  initial begin
    for (int i = 0; i < depth_words; i++) begin
      words[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
    end
    // head at 0, then 0x100 (256 bytes) and 0x300 (64 bytes)
    words[0]     = 32'h0000_0100;
    words[32'h40] = 32'd256;
    words[32'h41] = 32'h0000_0300;
    words[32'hc0] = 32'd64;
    words[32'hc1] = 32'h0000_0000;
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      rsp_val_q <= 1'b0;
      wait_q    <= 0;
    end else if (!busy_q) begin
      if (req_val_i) begin
        busy_q <= 1'b1;
        wait_q <= latency;
        if (req_is_write_i) begin
          words[idx] <= req_data_i;
        end else begin
          rdata_q <= words[idx];
        end
      end
    end else if (rsp_val_q) begin
      if (rsp_rdy_i) begin
        rsp_val_q <= 1'b0;
        busy_q    <= 1'b0;
      end
    end else if (wait_q == 0) begin
      rsp_val_q <= 1'b1;
    end else begin
      wait_q <= wait_q - 1;
    end
  end

endmodule

// File: verif/tb_alloc_core.sv
`timescale 1ns/1ps

module tb_alloc_core;
  import alloc_pkg::*;

  localparam int n_entries      = 12;
  localparam int timeout_cycles = 400;

  typedef struct packed {
    logic  is_free;
    word_t value;     // size or user pointer
    word_t expected;  // response, unused for free
    word_t hold;      // cycles with resp_full_i high
  } entry_t;

  entry_t stim [n_entries] = '{
    '{1'b0, 32'd0,    32'h0000_0000, 32'd0},   // zero size
    '{1'b0, 32'd20,   32'h0000_0108, 32'd0},   // aligned to 24, split
    '{1'b0, 32'd60,   32'h0000_0128, 32'd0},
    '{1'b0, 32'd56,   32'h0000_0170, 32'd0},
    '{1'b0, 32'd4096, 32'hffff_ffff, 32'd0},   // nothing fits
    '{1'b1, 32'h108,  32'h0000_0000, 32'd0},   // back in front of the list
    '{1'b0, 32'd24,   32'h0000_0108, 32'd0},   // exact fit, unlinked
    '{1'b0, 32'd8,    32'h0000_01b0, 32'd120}, // response FIFO full
    '{1'b0, 32'd64,   32'h0000_01c0, 32'd0},   // remainder 8, no split
    '{1'b0, 32'd64,   32'h0000_0308, 32'd0},
    '{1'b0, 32'd8,    32'hffff_ffff, 32'd0},   // empty list
    '{1'b1, 32'h1c0,  32'h0000_0000, 32'd0}
  };

  logic  clk_i;
  logic  rst_ni;
  logic  alloc_empty_i = 1'b1;
  logic  alloc_read_o;
  word_t alloc_data_i  = '0;
  logic  free_empty_i  = 1'b1;
  logic  free_read_o;
  word_t free_data_i   = '0;
  logic  resp_full_i;
  logic  resp_write_o;
  word_t resp_data_o;
  logic  mem_req_val_o;
  logic  mem_req_rdy_i;
  logic  mem_req_is_write_o;
  word_t mem_req_addr_o;
  word_t mem_req_data_o;
  logic  mem_rsp_val_i;
  logic  mem_rsp_rdy_o;
  word_t mem_rsp_data_i;

  // request and response FIFOs
  word_t alloc_buf [16];
  word_t free_buf [16];
  word_t resp_buf [16];
  int    alloc_wr = 0;
  int    alloc_rd = 0;
  int    free_wr = 0;
  int    free_rd = 0;
  int    resp_wr = 0;
  int    resp_rd = 0;

  int    write_count = 0;
  int    full_writes = 0;
  int    errors = 0;

  // reference free list, address ordered
  word_t m_addr [$];
  word_t m_size [$];
  word_t used_size [word_t];  // size word of each handed-out block

  alloc_core_top dut_i (.*);

  heap_mem_model mem_i (
    .clk_i,
    .rst_ni,
    .req_val_i      (mem_req_val_o),
    .req_rdy_o      (mem_req_rdy_i),
    .req_is_write_i (mem_req_is_write_o),
    .req_addr_i     (mem_req_addr_o),
    .req_data_i     (mem_req_data_o),
    .rsp_val_o      (mem_rsp_val_i),
    .rsp_rdy_i      (mem_rsp_rdy_o),
    .rsp_data_o     (mem_rsp_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // first word falls through
  always @(posedge clk_i) begin
    if (alloc_read_o) alloc_rd = alloc_rd + 1;
    if (free_read_o) free_rd = free_rd + 1;
    alloc_empty_i <= (alloc_rd == alloc_wr);
    alloc_data_i  <= alloc_buf[alloc_rd];
    free_empty_i  <= (free_rd == free_wr);
    free_data_i   <= free_buf[free_rd];
  end

  always @(posedge clk_i) begin
    if (rst_ni && resp_write_o) begin
      assert (!resp_full_i) else begin
        $display("response written while the response FIFO was full");
        full_writes <= full_writes + 1;
      end
      resp_buf[resp_wr] <= resp_data_o;
      resp_wr           <= resp_wr + 1;
    end
    if (rst_ni && mem_req_val_o && mem_req_rdy_i && mem_req_is_write_o) begin
      write_count <= write_count + 1;
    end
  end

  function automatic word_t model_alloc(word_t req);
    word_t need;
    word_t blk;
    word_t rem;
    if (req == 32'd0) begin
      return 32'h0;
    end
    need = (req + 32'd7) & ~32'd7;  // 8-byte granule
    for (int i = 0; i < m_addr.size(); i++) begin
      if (m_size[i] >= need) begin
        blk = m_addr[i];
        rem = m_size[i] - need;
        if (rem >= 32'd16) begin
          m_addr[i]      = blk + 32'd8 + need;
          m_size[i]      = rem - 32'd8;
          used_size[blk] = need;
        end else begin
          used_size[blk] = m_size[i];
          m_addr.delete(i);
          m_size.delete(i);
        end
        return blk + 32'd8;
      end
    end
    return 32'hffff_ffff;
  endfunction

  function automatic void model_free(word_t ptr);
    word_t blk;
    int    pos;
    blk = ptr - 32'd8;
    pos = m_addr.size();
    for (int i = m_addr.size() - 1; i >= 0; i--) begin
      if (m_addr[i] > blk) pos = i;
    end
    m_addr.insert(pos, blk);
    m_size.insert(pos, used_size[blk]);
  endfunction

  // walk the list in the heap and compare with the reference
  task automatic check_list();
    word_t      ptr;
    logic [9:0] wi;
    ptr = mem_i.words[0];
    for (int i = 0; i < m_addr.size(); i++) begin
      wi = ptr[11:2];
      assert (ptr == m_addr[i]) else begin
        $display("error: free list link %0d is 0x%h, expected 0x%h", i, ptr, m_addr[i]);
        errors++;
      end
      assert (mem_i.words[wi] == m_size[i]) else begin
        $display("error: size word at 0x%h is 0x%h, expected 0x%h",
                 ptr, mem_i.words[wi], m_size[i]);
        errors++;
      end
      ptr = mem_i.words[wi + 10'd1];
    end
    assert (ptr == 32'h0) else begin
      $display("error: last next_ptr is 0x%h, expected 0x%h", ptr, 32'h0);
      errors++;
    end
  endtask

  task automatic apply_entry(input int idx);
    entry_t e;
    word_t  predicted;
    word_t  got;
    int     errs_before;
    int     writes_before;
    int     n;
    string  kind_s;
    e             = stim[idx];
    errs_before   = errors;
    writes_before = write_count;
    n             = 0;
    if (e.hold != 0) begin
      @(posedge clk_i);
      resp_full_i <= 1'b1;
    end
    @(negedge clk_i);
    if (e.is_free) begin
      kind_s = "free";
      model_free(e.value);
      free_buf[free_wr] = e.value;
      free_wr++;
      // done after two writes with the memory port idle
      while ((write_count < writes_before + 2 || mem_req_val_o || mem_rsp_rdy_o) &&
             n < timeout_cycles) begin
        @(negedge clk_i);
        n++;
      end
      assert (n < timeout_cycles) else begin
        $display("free of 0x%h did not finish within %0d cycles", e.value, timeout_cycles);
        errors++;
      end
    end else begin
      kind_s    = "alloc";
      predicted = model_alloc(e.value);
      assert (predicted == e.expected) else begin
        $display("list model gives 0x%h for entry %0d but the table has 0x%h",
                 predicted, idx, e.expected);
        errors++;
      end
      alloc_buf[alloc_wr] = e.value;
      alloc_wr++;
      while (resp_rd == resp_wr && n < timeout_cycles) begin
        if (e.hold != 0 && n == e.hold) begin
          @(posedge clk_i);
          resp_full_i <= 1'b0;
        end
        @(negedge clk_i);
        n++;
      end
      if (resp_full_i) begin
        @(posedge clk_i);
        resp_full_i <= 1'b0;
      end
      assert (resp_rd != resp_wr) else begin
        $display("no response to entry %0d within %0d cycles", idx, timeout_cycles);
        errors++;
      end
      if (resp_rd != resp_wr) begin
        got = resp_buf[resp_rd];
        resp_rd++;
        assert (got == e.expected) else begin
          $display("error: resp_data_o 0x%h, expected 0x%h", got, e.expected);
          errors++;
        end
      end
      // zero size and out of memory leave the heap alone
      if (e.expected == 32'h0 || e.expected == 32'hffff_ffff) begin
        assert (write_count == writes_before) else begin
          $display("error: mem_req_is_write_o count 0x%h, expected 0x%h",
                   write_count - writes_before, 0);
          errors++;
        end
      end
    end
    check_list();
    if (errors == errs_before) begin
      $display("entry %0d %s 0x%h ok", idx, kind_s, e.value);
    end else begin
      $display("entry %0d %s 0x%h mismatch", idx, kind_s, e.value);
    end
  endtask

  initial begin
    rst_ni      = 1'b0;
    resp_full_i = 1'b0;
    m_addr      = '{32'h100, 32'h300};
    m_size      = '{32'd256, 32'd64};
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_list();
    for (int i = 0; i < n_entries; i++) begin
      apply_entry(i);
    end
    errors = errors + full_writes;
    $display("%0d entries applied, %0d errors", n_entries, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
common/alloc_pkg.sv
common/cmd_if.sv
common/lsu_if.sv
hw/cmd_decoder.sv
allocator/block_lsu.sv
allocator/freelist_walker.sv
hw/alloc_core_top.sv
verif/heap_mem_model.sv
verif/tb_alloc_core.sv

// File: run.sh
#!/bin/sh
# build and run the allocator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_alloc_core -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_alloc_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
